//--- Bender.yml
package:
  name: lcd_driver

sources:
  - files:
      - source/lcdPkg.sv
      - source/phaseSequencer.sv
      - source/levelPwm.sv
      - source/segmentSelect.sv
      - source/pinDriver.sv
      - source/lcdDriver.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/lcdDriverTb.sv

//--- build.f
+incdir+verif
source/lcdPkg.sv
source/phaseSequencer.sv
source/levelPwm.sv
source/segmentSelect.sv
source/pinDriver.sv
source/lcdDriver.sv
verif/lcdDriverTb.sv

//--- source/lcdDriver.sv
// Top level of the 4-backplane LCD controller; set ClockHz and PhaseUs for the target clock
`default_nettype none

module lcdDriver
	import lcdPkg::*;
#(
	parameter int ClockHz = 10_000_000,
	parameter int PhaseUs = 1000
)(
	input  wire                Clock,
	input  wire                Reset,
	input  wire displayFrame_t Frame_i,
	// Each line needs an RC filter to recover the analog level
	output lcdPins_t           Pins_o
);

	phase_t                  phase;
	logic [SegLineCount-1:0] segOn;
	logic                    pwmThird;
	logic                    pwmTwoThirds;

	phaseSequencer #(
		.ClockHz(ClockHz),
		.PhaseUs(PhaseUs)
	) i_phaseSequencer (
		.Clock(Clock),
		.Reset(Reset),
		.Phase_o(phase)
	);

	levelPwm i_levelPwm (
		.Clock(Clock),
		.Reset(Reset),
		.PwmThird_o(pwmThird),
		.PwmTwoThirds_o(pwmTwoThirds)
	);

	segmentSelect i_segmentSelect (
		.Frame_i(Frame_i),
		.Phase_i(phase),
		.SegOn_o(segOn)
	);

	pinDriver i_pinDriver (
		.Clock(Clock),
		.Reset(Reset),
		.Phase_i(phase),
		.SegOn_i(segOn),
		.PwmThird_i(pwmThird),
		.PwmTwoThirds_i(pwmTwoThirds),
		.Pins_o(Pins_o)
	);

endmodule

`default_nettype wire

//--- source/lcdPkg.sv
// Glass geometry, segment bit positions and drive types shared by every LCD controller module
`default_nettype none

package lcdPkg;

	localparam int CharCount = 8;
	localparam int ComCount = 4;
	// Groups per character in line order: ABCP, FED, IJKN, HGLM
	localparam int LineGroupCount = 4;
	localparam int SegLineCount = CharCount * LineGroupCount;

	// Bits 0..13 are segments a..n, bit 14 is the point
	typedef logic [14:0] glyph_t;

	// Index 0 is the rightmost character
	typedef glyph_t [CharCount-1:0] displayFrame_t;

	typedef logic [3:0] segIndex_t;

	localparam segIndex_t segA = 4'd0;
	localparam segIndex_t segB = 4'd1;
	localparam segIndex_t segC = 4'd2;
	localparam segIndex_t segD = 4'd3;
	localparam segIndex_t segE = 4'd4;
	localparam segIndex_t segF = 4'd5;
	localparam segIndex_t segG = 4'd6;
	localparam segIndex_t segH = 4'd7;
	localparam segIndex_t segI = 4'd8;
	localparam segIndex_t segJ = 4'd9;
	localparam segIndex_t segK = 4'd10;
	localparam segIndex_t segL = 4'd11;
	localparam segIndex_t segM = 4'd12;
	localparam segIndex_t segN = 4'd13;
	localparam segIndex_t segP = 4'd14;
	// Nothing on the glass behind this line for that common
	localparam segIndex_t segNone = 4'd15;

	// Rows are line groups, columns are common lines
	localparam segIndex_t segmentOrder [LineGroupCount][ComCount] = '{
		'{segA, segB, segC, segP},
		'{segNone, segF, segE, segD},
		'{segI, segJ, segK, segN},
		'{segH, segG, segL, segM}
	};

	// Drive level in thirds of the supply
	typedef logic [1:0] level_t;

	localparam level_t LevelZero = 2'd0;
	localparam level_t LevelThird = 2'd1;
	localparam level_t LevelTwoThirds = 2'd2;
	localparam level_t LevelFull = 2'd3;

	// Counts 0H..3H then 0L..3L
	typedef struct packed {
		logic       lowHalf;
		logic [1:0] comIndex;
	} phase_t;

	// Segment line index is character * 4 + group
	typedef struct packed {
		logic [ComCount-1:0]     com;
		logic [SegLineCount-1:0] seg;
	} lcdPins_t;

endpackage

`default_nettype wire

//--- source/levelPwm.sv
// Free-running divide-by-three PWM giving the 1/3 and 2/3 duty waveforms for the drive levels
`default_nettype none

module levelPwm (
	input  wire  Clock,
	input  wire  Reset,
	output logic PwmThird_o,
	output logic PwmTwoThirds_o
);

	logic [1:0] step;

	// Mod-3 counter
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			step <= 2'd0;
		end else if (step == 2'd2) begin
			step <= 2'd0;
		end else begin
			step <= step + 2'd1;
		end
	end

	// Registered decode keeps the outputs glitch free
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			PwmThird_o <= 1'b0;
			PwmTwoThirds_o <= 1'b0;
		end else begin
			PwmThird_o <= (step == 2'd0);
			PwmTwoThirds_o <= (step != 2'd2);
		end
	end

endmodule

`default_nettype wire

//--- source/phaseSequencer.sv
// Steps the eight drive phases of the glass, one every PhaseUs microseconds of Clock
`default_nettype none

module phaseSequencer
	import lcdPkg::*;
#(
	parameter int ClockHz = 10_000_000,
	parameter int PhaseUs = 1000
)(
	input  wire    Clock,
	input  wire    Reset,
	output phase_t Phase_o
);

	localparam longint PhaseCycles = longint'(ClockHz) * PhaseUs / 1_000_000;
	localparam int CountWidth = (PhaseCycles > 1) ? $clog2(PhaseCycles) : 1;
	localparam logic [CountWidth-1:0] LastCount = CountWidth'(PhaseCycles - 1);

	logic [CountWidth-1:0] cycleCount;
	logic                  phaseStrobe;

	assign phaseStrobe = (cycleCount == LastCount);

	// Phase period counter
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			cycleCount <= '0;
		end else if (phaseStrobe) begin
			cycleCount <= '0;
		end else begin
			cycleCount <= cycleCount + 1'b1;
		end
	end

	// Carry out of comIndex flips the polarity half
	// so each common sees both halves once per frame
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			Phase_o <= '0;
		end else if (phaseStrobe) begin
			Phase_o <= phase_t'(Phase_o + 3'd1);
		end
	end

endmodule

`default_nettype wire

//--- source/pinDriver.sv
// Encodes every common and segment line into a drive level and registers its PWM bit
`default_nettype none

module pinDriver
	import lcdPkg::*;
(
	input  wire                    Clock,
	input  wire                    Reset,
	input  wire phase_t            Phase_i,
	input  wire [SegLineCount-1:0] SegOn_i,
	input  wire                    PwmThird_i,
	input  wire                    PwmTwoThirds_i,
	output lcdPins_t               Pins_o
);

	level_t   comLevels [ComCount];
	level_t   segLevels [SegLineCount];
	lcdPins_t pinsNext;

	// Active common at the rail of its half, inactive ones one third inside
	function automatic level_t comLevel(input logic active, input logic lowHalf);
		case ({lowHalf, active})
			2'b01:   return LevelFull;
			2'b00:   return LevelThird;
			2'b11:   return LevelZero;
			default: return LevelTwoThirds;
		endcase
	endfunction

	// On segments sit opposite the active common
	function automatic level_t segLevel(input logic on, input logic lowHalf);
		case ({lowHalf, on})
			2'b01:   return LevelZero;
			2'b00:   return LevelTwoThirds;
			2'b11:   return LevelFull;
			default: return LevelThird;
		endcase
	endfunction

	function automatic logic levelBit(input level_t level, input logic third, input logic twoThirds);
		case (level)
			LevelZero:      return 1'b0;
			LevelThird:     return third;
			LevelTwoThirds: return twoThirds;
			default:        return 1'b1;
		endcase
	endfunction

	always_comb begin
		for (int i = 0; i < ComCount; i++) begin
			comLevels[i] = comLevel(Phase_i.comIndex == i, Phase_i.lowHalf);
			pinsNext.com[i] = levelBit(comLevels[i], PwmThird_i, PwmTwoThirds_i);
		end
		for (int i = 0; i < SegLineCount; i++) begin
			segLevels[i] = segLevel(SegOn_i[i], Phase_i.lowHalf);
			pinsNext.seg[i] = levelBit(segLevels[i], PwmThird_i, PwmTwoThirds_i);
		end
	end

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			Pins_o <= '0;
		end else begin
			Pins_o <= pinsNext;
		end
	end

endmodule

`default_nettype wire

//--- source/segmentSelect.sv
// Picks for each segment line the glyph bit shown on the currently active common
`default_nettype none

module segmentSelect
	import lcdPkg::*;
(
	input  wire displayFrame_t      Frame_i,
	input  wire phase_t             Phase_i,
	output logic [SegLineCount-1:0] SegOn_o
);

	// Only the common index matters here
	// polarity is applied in the pin driver
	function automatic logic lineOn(
		input glyph_t    glyph,
		input int        group,
		input logic [1:0] comIndex
	);
		segIndex_t bitIndex;
		bitIndex = segmentOrder[group][comIndex];
		if (bitIndex == segNone) begin
			return 1'b0;
		end
		return glyph[bitIndex];
	endfunction

	genvar c;
	genvar g;
	generate
		for (c = 0; c < CharCount; c++) begin : charLines
			for (g = 0; g < LineGroupCount; g++) begin : groupLines
				assign SegOn_o[c*LineGroupCount + g] = lineOn(Frame_i[c], g, Phase_i.comIndex);
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- verif/lcdDriverChecks.svh
// Xorshift stimulus, reference model of the drive levels and typed compare tasks for lcdDriverTb
`ifndef LCD_DRIVER_CHECKS_SVH
`define LCD_DRIVER_CHECKS_SVH

function automatic logic [31:0] nextRandom();
	rngState ^= rngState << 13;
	rngState ^= rngState >> 17;
	rngState ^= rngState << 5;
	return rngState;
endfunction

// Glyph bit behind a line group on a common
// Returns -1 where the glass has none
function automatic int shownBit(input int group, input int com);
	int bits [4];
	case (group)
		0:       bits = '{0, 1, 2, 14};
		1:       bits = '{-1, 5, 4, 3};
		2:       bits = '{8, 9, 10, 13};
		default: bits = '{7, 6, 11, 12};
	endcase
	return bits[com];
endfunction

function automatic level_t encodeCom(input logic active, input logic lowHalf);
	if (!lowHalf) begin
		return active ? 2'd3 : 2'd1;
	end
	return active ? 2'd0 : 2'd2;
endfunction

// On segments sit opposite the active common
function automatic level_t encodeSeg(input logic on, input logic lowHalf);
	if (!lowHalf) begin
		return on ? 2'd0 : 2'd2;
	end
	return on ? 2'd3 : 2'd1;
endfunction

function automatic level_t refComLevel(input int com, input int phaseNum);
	return encodeCom(com == phaseNum % ComCount, phaseNum >= ComCount);
endfunction

function automatic level_t refSegLevel(input displayFrame_t frame, input int line,
		input int phaseNum);
	int bitIndex;
	logic on;
	bitIndex = shownBit(line % LineGroupCount, phaseNum % ComCount);
	on = 1'b0;
	if (bitIndex >= 0) begin
		on = frame[line / LineGroupCount][bitIndex];
	end
	return encodeSeg(on, phaseNum >= ComCount);
endfunction

task automatic compareLevel(input level_t expected, input level_t actual,
		input string testName, input string lineName);
	checkCount++;
	if (actual !== expected) begin
		errorCount++;
		$display("CHECK FAILED %s %s: expected level %0d, actual %0d",
			testName, lineName, expected, actual);
	end
endtask

task automatic comparePins(input lcdPins_t expected, input lcdPins_t actual,
		input string testName);
	checkCount++;
	if (actual !== expected) begin
		errorCount++;
		$display("CHECK FAILED %s pins: expected %h, actual %h", testName, expected, actual);
	end
endtask

`endif

//--- verif/lcdDriverTb.sv
// Directed testbench for the LCD controller; compile with build.f and run lcdDriverTb as top
`default_nettype none

module lcdDriverTb
	import lcdPkg::*;
();

	localparam int ClockHz = 1_000_000;
	localparam int PhaseUs = 30;
	localparam int PhaseCycles = ClockHz * PhaseUs / 1_000_000;
	localparam int WaitLimit = 16 * PhaseCycles;

	logic          Clock;
	logic          Reset;
	displayFrame_t frame;
	lcdPins_t      pins;

	// Rising edges since the edge that released reset
	int            edgeCount;
	int            errorCount;
	int            checkCount;
	logic [31:0]   rngState = 32'h3e63;
	level_t        comMeasured [ComCount];
	level_t        segMeasured [SegLineCount];

	`include "lcdDriverChecks.svh"

	lcdDriver #(
		.ClockHz(ClockHz),
		.PhaseUs(PhaseUs)
	) i_lcdDriver (
		.Clock(Clock),
		.Reset(Reset),
		.Frame_i(frame),
		.Pins_o(pins)
	);

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	task automatic tick();
		@(posedge Clock);
		edgeCount++;
	endtask

	task automatic advanceTo(input int target);
		for (int n = 0; n < WaitLimit && edgeCount < target; n++) begin
			tick();
		end
		if (edgeCount != target) begin
			$display("Timeout: waiting for cycle %0d of the run, stopped at cycle %0d",
				target, edgeCount);
			$display("Result: FAILED");
			$finish;
		end
	endtask

	task automatic setFrame(input displayFrame_t newFrame);
		tick();
		frame <= newFrame;
	endtask

	// Counts high samples over three cycles in the middle of a phase window
	task automatic measureWindow(input int window);
		int comHigh [ComCount] = '{default: 0};
		int segHigh [SegLineCount] = '{default: 0};
		advanceTo(window * PhaseCycles + PhaseCycles / 2 - 2);
		repeat (3) begin
			tick();
			@(negedge Clock);
			foreach (comHigh[i]) begin
				comHigh[i] += pins.com[i];
			end
			foreach (segHigh[i]) begin
				segHigh[i] += pins.seg[i];
			end
		end
		foreach (comMeasured[i]) begin
			comMeasured[i] = level_t'(comHigh[i]);
		end
		foreach (segMeasured[i]) begin
			segMeasured[i] = level_t'(segHigh[i]);
		end
	endtask

	task automatic checkWindow(input int window, input displayFrame_t shown, input string testName);
		measureWindow(window);
		for (int i = 0; i < ComCount; i++) begin
			compareLevel(refComLevel(i, window % 8), comMeasured[i], testName,
				$sformatf("com%0d", i));
		end
		for (int i = 0; i < SegLineCount; i++) begin
			compareLevel(refSegLevel(shown, i, window % 8), segMeasured[i], testName,
				$sformatf("seg%0d", i));
		end
	endtask

	function automatic displayFrame_t randomFrame();
		displayFrame_t f;
		for (int c = 0; c < CharCount; c++) begin
			f[c] = glyph_t'(nextRandom());
		end
		return f;
	endfunction

	task automatic reportTest(input string testName, input int errorsBefore);
		$display("Test %s finished with %0d errors", testName, errorCount - errorsBefore);
	endtask

	task automatic blankFrameTest();
		int errorsBefore;
		errorsBefore = errorCount;
		for (int i = 0; i < 8; i++) begin
			tick();
			@(negedge Clock);
			comparePins('0, pins, "blankFrame");
		end
		tick();
		Reset <= 1'b1;
		edgeCount = 0;
		measureWindow(0);
		for (int i = 0; i < ComCount; i++) begin
			compareLevel((i == 0) ? 2'd3 : 2'd1, comMeasured[i], "blankFrame",
				$sformatf("com%0d", i));
		end
		for (int i = 0; i < SegLineCount; i++) begin
			compareLevel(2'd2, segMeasured[i], "blankFrame", $sformatf("seg%0d", i));
		end
		reportTest("blankFrame", errorsBefore);
	endtask

	task automatic singleSegmentTest();
		int errorsBefore;
		displayFrame_t f;
		errorsBefore = errorCount;
		f = '0;
		f[0][segA] = 1'b1;
		setFrame(f);
		// Window 8 is 0H, window 12 is 0L
		measureWindow(8);
		for (int i = 0; i < SegLineCount; i++) begin
			compareLevel((i == 0) ? 2'd0 : 2'd2, segMeasured[i], "singleSegment",
				$sformatf("seg%0d", i));
		end
		measureWindow(12);
		for (int i = 0; i < SegLineCount; i++) begin
			compareLevel((i == 0) ? 2'd3 : 2'd1, segMeasured[i], "singleSegment",
				$sformatf("seg%0d", i));
		end
		reportTest("singleSegment", errorsBefore);
	endtask

	task automatic randomFrameTest();
		int errorsBefore;
		displayFrame_t f;
		errorsBefore = errorCount;
		f = randomFrame();
		setFrame(f);
		for (int w = 16; w < 24; w++) begin
			checkWindow(w, f, "randomFrame");
		end
		reportTest("randomFrame", errorsBefore);
	endtask

	task automatic fedGroupTest();
		int errorsBefore;
		int phaseNum;
		logic on;
		errorsBefore = errorCount;
		setFrame('1);
		for (int w = 24; w < 32; w++) begin
			measureWindow(w);
			phaseNum = w % 8;
			for (int i = 0; i < SegLineCount; i++) begin
				on = !(i % LineGroupCount == 1 && phaseNum % ComCount == 0);
				compareLevel(encodeSeg(on, phaseNum >= ComCount), segMeasured[i], "fedGroup",
					$sformatf("seg%0d", i));
			end
		end
		reportTest("fedGroup", errorsBefore);
	endtask

	task automatic wrapAndUpdateTest();
		int errorsBefore;
		displayFrame_t f;
		errorsBefore = errorCount;
		checkWindow(32, '1, "wrapAndUpdate");
		checkWindow(33, '1, "wrapAndUpdate");
		// New frame lands between two sampled windows
		advanceTo(33 * PhaseCycles + 20);
		f = randomFrame();
		setFrame(f);
		for (int w = 34; w < 42; w++) begin
			checkWindow(w, f, "wrapAndUpdate");
		end
		reportTest("wrapAndUpdate", errorsBefore);
	endtask

	initial begin
		Reset = 1'b0;
		frame = '0;
		edgeCount = 0;
		errorCount = 0;
		checkCount = 0;
		blankFrameTest();
		singleSegmentTest();
		randomFrameTest();
		fedGroupTest();
		wrapAndUpdateTest();
		$display("Summary: 5 tests, %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
